//--- verilog/apu_regs_pkg.sv
package apu_regs_pkg;

	// register window offsets
	localparam logic [7:0] NR30_ADDR      = 8'h1a; // dac enable
	localparam logic [7:0] NR32_ADDR      = 8'h1c; // output level
	localparam logic [7:0] NR33_ADDR      = 8'h1d; // period low byte
	localparam logic [7:0] NR34_ADDR      = 8'h1e; // period high, trigger
	localparam logic [7:0] WAVE_BASE_ADDR = 8'h30; // wave ram window start

	// field positions inside the register bytes
	localparam int DAC_BIT     = 7;
	localparam int LEVEL_LSB   = 5;
	localparam int LEVEL_W     = 2;
	localparam int TRIG_BIT    = 7;

	// storage geometry
	localparam int WAVE_BYTES   = 16;
	localparam int WAVE_SAMPLES = 32;
	localparam int IDX_W        = $clog2(WAVE_BYTES);
	localparam int POS_W        = $clog2(WAVE_SAMPLES);

	// timing
	localparam int PERIOD_W    = 11;
	localparam int PERIOD_HI_W = PERIOD_W - 8; // bits held in nr34
	localparam int TIMER_DIV   = 2; // clocks per timer step, at least 2
	localparam int DIV_W       = $clog2(TIMER_DIV);
	localparam logic [PERIOD_W-1:0] TIMER_MAX = '1;

	// output flow control
	localparam int SAMPLE_CREDITS = 4;
	localparam int CREDIT_W       = 3;

endpackage

//--- verilog/wave_pkg.sv
package wave_pkg;

	import apu_regs_pkg::*;

	// one cpu bus access
	typedef struct packed {
		logic       valid;
		logic       wr;
		logic [7:0] addr;
		logic [7:0] wdata;
	} cpu_req_t;

	// held channel control, trigger is a single cycle pulse
	typedef struct packed {
		logic                dac_on;
		logic [LEVEL_W-1:0]  level;
		logic [PERIOD_W-1:0] period;
		logic                trigger;
	} chan_ctrl_t;

	// cpu access aimed at the wave ram
	typedef struct packed {
		logic             valid;
		logic             wr;
		logic [IDX_W-1:0] idx;
		logic [7:0]       data;
	} wave_access_t;

	// playback request from the sequencer
	typedef struct packed {
		logic             valid;
		logic [POS_W-1:0] pos;
		logic             active;
	} wave_fetch_t;

	typedef struct packed {
		logic       valid;
		logic [3:0] sample;
	} sample_t;

endpackage

//--- verilog/wave_cpu_port.sv
`timescale 1ns/1ps

module wave_cpu_port import apu_regs_pkg::*, wave_pkg::*; (
	input  logic         amuk_4mhz,
	input  logic         rst,
	input  cpu_req_t     cpu_req,
	output chan_ctrl_t   chan_ctrl,
	output wave_access_t wave_acc
);

	logic wr_en;
	logic in_wave;

	assign wr_en   = cpu_req.valid && cpu_req.wr;
	assign in_wave = (cpu_req.addr >= WAVE_BASE_ADDR) &&
		(cpu_req.addr < WAVE_BASE_ADDR + 8'(WAVE_BYTES));

	// channel control registers
	always_ff @(posedge amuk_4mhz) begin
		if (rst) begin
			chan_ctrl <= '0;
		end else begin
			chan_ctrl.trigger <= 1'b0; // pulse, cleared unless rewritten
			if (wr_en) begin
				case (cpu_req.addr)
					NR30_ADDR: begin
						chan_ctrl.dac_on <= cpu_req.wdata[DAC_BIT];
					end
					NR32_ADDR: begin
						chan_ctrl.level <= cpu_req.wdata[LEVEL_LSB +: LEVEL_W];
					end
					NR33_ADDR: begin
						chan_ctrl.period[7:0] <= cpu_req.wdata;
					end
					NR34_ADDR: begin
						chan_ctrl.period[PERIOD_W-1:8] <= cpu_req.wdata[PERIOD_HI_W-1:0];
						chan_ctrl.trigger              <= cpu_req.wdata[TRIG_BIT];
					end
					default: begin
					end
				endcase
			end
		end
	end

	// wave window accesses, one cycle late
	always_ff @(posedge amuk_4mhz) begin
		if (rst) begin
			wave_acc.valid <= 1'b0;
		end else begin
			wave_acc.valid <= cpu_req.valid && in_wave;
			wave_acc.wr    <= cpu_req.wr;
			wave_acc.idx   <= cpu_req.addr[IDX_W-1:0]; // low nibble picks the byte
			wave_acc.data  <= cpu_req.wdata;
		end
	end

	// back to back nr34 writes still give separate pulses downstream
	// only if the bus leaves a gap, which the sequencer relies on
	assert property (@(posedge amuk_4mhz) disable iff (rst)
		chan_ctrl.trigger |=> !chan_ctrl.trigger);

endmodule

//--- verilog/wave_sequencer.sv
`timescale 1ns/1ps

module wave_sequencer import apu_regs_pkg::*, wave_pkg::*; (
	input  logic        amuk_4mhz,
	input  logic        rst,
	input  chan_ctrl_t  chan_ctrl,
	input  logic        credit_return,
	output wave_fetch_t wave_fetch
);

	logic [DIV_W-1:0]    div_cnt;
	logic [PERIOD_W-1:0] timer;
	logic [POS_W-1:0]    pos;
	logic                active;
	logic                stalled;
	logic [CREDIT_W-1:0] credits;

	logic tick;
	logic at_top;
	logic due;
	logic advance;

	assign tick    = (div_cnt == DIV_W'(TIMER_DIV - 1));
	assign at_top  = (timer == TIMER_MAX);
	assign due     = active && at_top && (tick || stalled); // overflow pending
	assign advance = due && (credits != '0) && !chan_ctrl.trigger;

	// fetch goes out in the advance cycle with the new position
	assign wave_fetch.valid  = advance;
	assign wave_fetch.pos    = pos + POS_W'(1);
	assign wave_fetch.active = active;

	always_ff @(posedge amuk_4mhz) begin
		if (rst) begin
			div_cnt <= '0;
			timer   <= '0;
			pos     <= '0;
			active  <= 1'b0;
			stalled <= 1'b0;
		end else if (chan_ctrl.trigger) begin
			div_cnt <= '0;
			timer   <= chan_ctrl.period;
			pos     <= '0;
			active  <= chan_ctrl.dac_on;
			stalled <= 1'b0;
		end else begin
			if (!chan_ctrl.dac_on) begin
				active <= 1'b0; // dac off stops playback
			end
			if (advance) begin
				timer   <= chan_ctrl.period; // reload on overflow
				pos     <= pos + POS_W'(1); // wraps at 32
				div_cnt <= '0;
				stalled <= 1'b0;
			end else if (due) begin
				stalled <= 1'b1; // no credit, hold at overflow
			end else if (active) begin
				if (tick) begin
					div_cnt <= '0;
					timer   <= timer + PERIOD_W'(1);
				end else begin
					div_cnt <= div_cnt + DIV_W'(1);
				end
			end
		end
	end

	// one credit per issued sample, one back per mixer return
	always_ff @(posedge amuk_4mhz) begin
		if (rst) begin
			credits <= CREDIT_W'(SAMPLE_CREDITS);
		end else begin
			credits <= credits + CREDIT_W'(credit_return) - CREDIT_W'(advance);
		end
	end

	assert property (@(posedge amuk_4mhz) disable iff (rst)
		credits <= CREDIT_W'(SAMPLE_CREDITS));

	// mixer may only return what it was given
	assert property (@(posedge amuk_4mhz) disable iff (rst)
		credit_return |-> credits != CREDIT_W'(SAMPLE_CREDITS));

	// no fetch in the cycle playback starts
	assert property (@(posedge amuk_4mhz) disable iff (rst)
		wave_fetch.valid |-> $past(active));

endmodule

//--- verilog/wave_ram.sv
`timescale 1ns/1ps

module wave_ram import apu_regs_pkg::*, wave_pkg::*; (
	input  logic               amuk_4mhz,
	input  logic               rst,
	input  wave_access_t       wave_acc,
	input  wave_fetch_t        wave_fetch,
	input  logic [LEVEL_W-1:0] level,
	output sample_t            sample_out,
	output logic [7:0]         cpu_rdata,
	output logic               cpu_rvalid
);

	logic [7:0] mem [WAVE_BYTES];

	logic [IDX_W-1:0] last_idx; // byte of the last fetch
	logic [IDX_W-1:0] cpu_idx;
	logic [IDX_W-1:0] fetch_idx;
	logic [7:0]       fetch_byte;
	logic [3:0]       nibble;
	logic [3:0]       shifted;

	// playing channel owns the ram, cpu sees the byte being played
	assign cpu_idx = wave_fetch.active ? last_idx : wave_acc.idx;

	assign fetch_idx  = wave_fetch.pos[POS_W-1:1];
	assign fetch_byte = mem[fetch_idx];
	assign nibble     = wave_fetch.pos[0] ? fetch_byte[3:0] : fetch_byte[7:4]; // even is high

	always_comb begin
		case (level)
			2'd0:    shifted = 4'd0; // mute
			2'd1:    shifted = nibble;
			2'd2:    shifted = nibble >> 1;
			default: shifted = nibble >> 2;
		endcase
	end

	// cpu writes, nba order puts them after a same cycle fetch read
	always_ff @(posedge amuk_4mhz) begin
		if (wave_acc.valid && wave_acc.wr) begin
			mem[cpu_idx] <= wave_acc.data;
		end
	end

	always_ff @(posedge amuk_4mhz) begin
		if (rst) begin
			last_idx <= '0;
		end else if (wave_fetch.valid) begin
			last_idx <= fetch_idx;
		end
	end

	// sample register, one cycle behind the fetch
	always_ff @(posedge amuk_4mhz) begin
		if (rst) begin
			sample_out.valid <= 1'b0;
		end else begin
			sample_out.valid <= wave_fetch.valid;
			if (wave_fetch.valid) begin
				sample_out.sample <= shifted;
			end
		end
	end

	// access was registered in the port, so the answer lands one cycle after the bus read
	assign cpu_rvalid = wave_acc.valid && !wave_acc.wr;
	assign cpu_rdata  = cpu_rvalid ? mem[cpu_idx] : 8'h00;

	// an answer always stems from a bus read issued after reset went away
	assert property (@(posedge amuk_4mhz) disable iff (rst)
		cpu_rvalid |-> !$past(rst));

endmodule

//--- verilog/wave_channel_top.sv
`timescale 1ns/1ps

module wave_channel_top import wave_pkg::*; (
	input  logic       amuk_4mhz,
	input  logic       rst,
	input  cpu_req_t   cpu_req,
	input  logic       credit_return, // one pulse per consumed sample
	output logic [7:0] cpu_rdata,
	output logic       cpu_rvalid,
	output sample_t    sample_out
);

	chan_ctrl_t   chan_ctrl;
	wave_access_t wave_acc;
	wave_fetch_t  wave_fetch;

	// register window and wave window decode
	wave_cpu_port u_cpu_port (
		.amuk_4mhz (amuk_4mhz),
		.rst       (rst),
		.cpu_req   (cpu_req),
		.chan_ctrl (chan_ctrl),
		.wave_acc  (wave_acc)
	);

	// timer, position and credits
	wave_sequencer u_sequencer (
		.amuk_4mhz     (amuk_4mhz),
		.rst           (rst),
		.chan_ctrl     (chan_ctrl),
		.credit_return (credit_return),
		.wave_fetch    (wave_fetch)
	);

	// storage and sample shaping
	wave_ram u_wave_ram (
		.amuk_4mhz  (amuk_4mhz),
		.rst        (rst),
		.wave_acc   (wave_acc),
		.wave_fetch (wave_fetch),
		.level      (chan_ctrl.level),
		.sample_out (sample_out),
		.cpu_rdata  (cpu_rdata),
		.cpu_rvalid (cpu_rvalid)
	);

endmodule

//--- verification/wave_channel_checks.svh
`ifndef WAVE_CHANNEL_CHECKS_SVH
`define WAVE_CHANNEL_CHECKS_SVH

int data_errors   = 0; // wrong read data
int sample_errors = 0; // wrong sample values
int flow_errors   = 0; // timing, missing or unexpected responses

task automatic check_rdata(input string name, input logic [7:0] exp);
	if (cpu_rdata !== exp) begin
		data_errors++;
		$display("Fail %s: expected %02h, actual %02h", name, exp, cpu_rdata);
	end
endtask

task automatic check_sample(input string name, input sample_t exp);
	if (sample_out !== exp) begin
		sample_errors++;
		$display("Fail %s: expected valid %b sample %h, actual valid %b sample %h",
			name, exp.valid, exp.sample, sample_out.valid, sample_out.sample);
	end
endtask

task automatic report_flow(input string msg);
	flow_errors++;
	$display("%s (%s, cycle %0d)", msg, cur_name, cycle_cnt);
endtask

function automatic int total_errors();
	return data_errors + sample_errors + flow_errors;
endfunction

`endif

//--- verification/wave_channel_tb.sv
`timescale 1ns/1ps

module wave_channel_tb import apu_regs_pkg::*, wave_pkg::*; ();

	localparam int NUM_CASES = 6;
	localparam int CASE_W    = $clog2(NUM_CASES);

	typedef struct packed {
		logic [PERIOD_W-1:0] period;
		logic [LEVEL_W-1:0]  level;
		logic [7:0]          seed;  // mixed into the wave pattern
		logic [15:0]         hold;  // cycles with credit returns withheld
		logic [7:0]          count; // samples to take
	} case_t;

	case_t cases [NUM_CASES] = '{
		'{11'd2000, 2'd1, 8'h11, 16'd0, 8'd33},   // full wrap at level 1
		'{11'd2030, 2'd0, 8'h5a, 16'd0, 8'd12},
		'{11'd2040, 2'd2, 8'ha3, 16'd0, 8'd20},
		'{11'd2044, 2'd3, 8'h3c, 16'd0, 8'd34},
		'{11'd2020, 2'd1, 8'h77, 16'd400, 8'd10}, // stalls on the fifth sample
		'{11'd2046, 2'd2, 8'hc5, 16'd40, 8'd8}
	};
	string case_names [NUM_CASES] = '{"order_l1", "mute_l0", "half_l2", "quarter_l3",
		"credit_hold", "fast_hold"};

	logic       amuk_4mhz = 1'b0;
	logic       rst;
	cpu_req_t   cpu_req;
	logic       credit_return;
	logic [7:0] cpu_rdata;
	logic       cpu_rvalid;
	sample_t    sample_out;

	int                 cycle_cnt = 0;
	int                 limit_cycles;
	logic [7:0]         wave_img [WAVE_BYTES]; // what the ram should hold
	logic [LEVEL_W-1:0] cur_level;
	string              cur_name = "reset";
	int                 spacing;
	int                 exp_cyc;
	int                 n_got;
	int                 owed_credits = 0;
	bit                 timed;
	bit                 expect_samples = 1'b0;
	bit                 hold_credits = 1'b0;

	`include "wave_channel_checks.svh"

	wave_channel_top u_dut (
		.amuk_4mhz     (amuk_4mhz),
		.rst           (rst),
		.cpu_req       (cpu_req),
		.credit_return (credit_return),
		.cpu_rdata     (cpu_rdata),
		.cpu_rvalid    (cpu_rvalid),
		.sample_out    (sample_out)
	);

	always begin
		#10 amuk_4mhz = ~amuk_4mhz;
	end

	always @(posedge amuk_4mhz) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= limit_cycles) begin
			$display("Timeout after %0d cycles, the run did not finish", cycle_cnt);
			$display("Result: FAILED");
			$finish;
		end
	end

	function automatic int run_limit();
		int total;
		int i;
		total = 0;
		for (i = 0; i < NUM_CASES; i++) begin
			total += int'(cases[CASE_W'(i)].count) * TIMER_DIV *
				(2048 - int'(cases[CASE_W'(i)].period)) + int'(cases[CASE_W'(i)].hold);
		end
		return total * 2 + 1000;
	endfunction

	// nibble of position k+1, high nibble first, then scaled by level
	function automatic sample_t expected_sample(input int k);
		int         pos;
		logic [7:0] byte_val;
		logic [3:0] nib;
		sample_t    s;
		pos      = (k + 1) % WAVE_SAMPLES;
		byte_val = wave_img[IDX_W'(pos / 2)];
		nib      = (pos % 2 == 0) ? byte_val[7:4] : byte_val[3:0];
		s.valid  = 1'b1;
		if (cur_level == 0) begin
			s.sample = 4'd0;
		end else begin
			s.sample = nib >> (int'(cur_level) - 1);
		end
		return s;
	endfunction

	task automatic take_sample();
		owed_credits++;
		if (!expect_samples) begin
			report_flow("a sample arrived while the channel should be silent");
		end else begin
			check_sample(cur_name, expected_sample(n_got));
			if (timed && cycle_cnt < exp_cyc) begin
				report_flow("a sample arrived earlier than its period allows");
			end
			if (hold_credits && n_got >= SAMPLE_CREDITS) begin
				report_flow("a sample was issued with no credit left");
			end
			n_got++;
			exp_cyc = cycle_cnt + spacing;
		end
	endtask

	// one clock, then observe outputs and drive the mixer credit line
	task automatic step_cycle();
		@(posedge amuk_4mhz);
		#1;
		credit_return = 1'b0;
		if (sample_out.valid) begin
			take_sample();
		end
		if (owed_credits > 0 && !hold_credits) begin
			credit_return = 1'b1;
			owed_credits--;
		end
	endtask

	task automatic bus_write(input logic [7:0] addr, input logic [7:0] data);
		cpu_req.valid = 1'b1;
		cpu_req.wr    = 1'b1;
		cpu_req.addr  = addr;
		cpu_req.wdata = data;
		step_cycle();
		cpu_req = '0;
	endtask

	task automatic bus_read(input logic [7:0] addr, output logic answered);
		cpu_req.valid = 1'b1;
		cpu_req.wr    = 1'b0;
		cpu_req.addr  = addr;
		cpu_req.wdata = 8'h00;
		step_cycle();
		cpu_req  = '0;
		answered = cpu_rvalid;
		if (!answered) begin
			report_flow("a wave ram read got no response one cycle later");
		end
	endtask

	task automatic run_case(input case_t tc, input string name);
		int   i;
		int   trig_cyc;
		int   hold_end;
		int   deadline;
		logic ok;
		logic redirect_done;
		cur_name = name;
		for (i = 0; i < WAVE_BYTES; i++) begin
			wave_img[IDX_W'(i)] = 8'($urandom()) ^ (tc.seed + 8'(i * 59));
			bus_write(WAVE_BASE_ADDR + 8'(i), wave_img[IDX_W'(i)]);
		end
		for (i = 0; i < WAVE_BYTES; i++) begin
			bus_read(WAVE_BASE_ADDR + 8'(i), ok);
			if (ok) begin
				check_rdata({name, "_ram"}, wave_img[IDX_W'(i)]);
			end
		end
		cur_level    = tc.level;
		spacing      = TIMER_DIV * (2048 - int'(tc.period));
		n_got        = 0;
		timed        = (tc.hold == 0);
		hold_credits = (tc.hold != 0);
		bus_write(NR32_ADDR, {1'b0, tc.level, 5'b0});
		bus_write(NR33_ADDR, tc.period[7:0]);
		bus_write(NR30_ADDR, 8'h80);
		expect_samples = 1'b1;
		trig_cyc = cycle_cnt;
		exp_cyc  = trig_cyc + spacing + 2; // first sample latency
		hold_end = trig_cyc + int'(tc.hold);
		deadline = hold_end + (int'(tc.count) + 1) * spacing + 50;
		bus_write(NR34_ADDR, {1'b1, 4'b0, tc.period[PERIOD_W-1:8]});
		redirect_done = 1'b0;
		while (n_got < int'(tc.count)) begin
			if (hold_credits && cycle_cnt >= hold_end) begin
				if (n_got != SAMPLE_CREDITS) begin
					report_flow("wrong number of samples while credits were withheld");
				end
				hold_credits = 1'b0;
			end
			if (!redirect_done && !hold_credits && n_got >= 2) begin
				bus_read(WAVE_BASE_ADDR + 8'((n_got * 7) % WAVE_BYTES), ok); // any index
				if (ok) begin
					check_rdata({name, "_redirect"}, wave_img[IDX_W'((n_got % WAVE_SAMPLES) / 2)]);
				end
				redirect_done = 1'b1;
			end else begin
				step_cycle();
			end
			if (timed && cycle_cnt > exp_cyc) begin
				report_flow("an expected sample did not arrive on time");
				break;
			end
			if (cycle_cnt > deadline) begin
				report_flow("samples are missing after the credits came back");
				break;
			end
		end
		expect_samples = 1'b0;
		hold_credits   = 1'b0;
		bus_write(NR30_ADDR, 8'h00); // dac off stops playback
		for (i = 0; i < 2 * spacing + 8; i++) begin
			step_cycle();
		end
	endtask

	initial begin
		int c;
		rst           = 1'b1;
		cpu_req       = '0;
		credit_return = 1'b0;
		void'($urandom(32'h7574_cb51));
		limit_cycles = run_limit();
		repeat (5) @(posedge amuk_4mhz);
		#1;
		rst = 1'b0;
		for (c = 0; c < NUM_CASES; c++) begin
			run_case(cases[CASE_W'(c)], case_names[CASE_W'(c)]);
		end
		$display("Errors: data %0d, sample %0d, flow %0d", data_errors, sample_errors,
			flow_errors);
		if (total_errors() == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

//--- sim.f
+incdir+verification
verilog/apu_regs_pkg.sv
verilog/wave_pkg.sv
verilog/wave_cpu_port.sv
verilog/wave_sequencer.sv
verilog/wave_ram.sv
verilog/wave_channel_top.sv
verification/wave_channel_tb.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module wave_channel_tb \
	-o wave_channel_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/wave_channel_sim)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "Result: PASSED"; then
	exit 0
fi
exit 1
